// File: all.f
+incdir+source
source/dma_pkg.sv
source/dma_ifs.sv
source/forward_stage.sv
source/chunk_head.sv
source/dram_addr_issuer.sv
source/sram_write_collector.sv
source/butterfly_write_if.sv
source/dma_pipeline.sv
bench/dram_responder.sv
bench/dma_pipeline_tb.sv

// File: bench/dma_pipeline_tb.sv
`include "dma_settings.svh"

module dma_pipeline_tb;

	localparam int n_chunks = 16;

	typedef struct packed {
		logic             which;
		dma_pkg::cfg_id_t cfg_id;
		dma_pkg::crd_t    row;
		dma_pkg::crd_t    col;
		dma_pkg::addr_t   addr;
	} stim_t;

	// Side, id, row, column and the DRAM address they should give
	stim_t chunks [n_chunks] = '{
		'{1'b0, 1'b0, 4'd1,  4'd2,  16'h0112},
		'{1'b1, 1'b1, 4'd2,  4'd3,  16'h3443},
		'{1'b0, 1'b1, 4'd3,  4'd4,  16'h084c},
		'{1'b1, 1'b0, 4'd5,  4'd1,  16'h202e},
		'{1'b1, 1'b1, 4'd0,  4'd7,  16'h3407},
		'{1'b0, 1'b0, 4'd15, 4'd15, 16'h01ff},
		'{1'b1, 1'b1, 4'd15, 4'd15, 16'h35ef},
		'{1'b0, 1'b1, 4'd7,  4'd0,  16'h08a8},
		'{1'b1, 1'b0, 4'd10, 4'd6,  16'h2060},
		'{1'b0, 1'b0, 4'd4,  4'd9,  16'h0149},
		'{1'b1, 1'b1, 4'd8,  4'd2,  16'h3502},
		'{1'b1, 1'b1, 4'd1,  4'd1,  16'h3421},
		'{1'b0, 1'b1, 4'd12, 4'd11, 16'h092b},
		'{1'b1, 1'b0, 4'd3,  4'd14, 16'h2029},
		'{1'b0, 1'b0, 4'd6,  4'd3,  16'h0163},
		'{1'b1, 1'b1, 4'd9,  4'd8,  16'h3528}
	};

	logic               clk = 1'b0;
	logic               rst;
	logic               bofs_rdy;
	logic               bofs_ack;
	logic               which;
	dma_pkg::cfg_id_t   cfg_id;
	dma_pkg::crd_t      row;
	dma_pkg::crd_t      col;
	dma_pkg::addr_t     cfg0_base  [`DMA_N_CFG];
	dma_pkg::addr_t     cfg1_base  [`DMA_N_CFG];
	dma_pkg::addr_t     cfg0_pitch [`DMA_N_CFG];
	dma_pkg::addr_t     cfg1_pitch [`DMA_N_CFG];
	dma_pkg::lane_sel_t cfg0_xor   [`DMA_N_CFG];
	dma_pkg::lane_sel_t cfg1_xor   [`DMA_N_CFG];
	logic               rp_en0_rdy;
	logic               rp_en0_ack;
	logic               rp_en1_rdy;
	logic               rp_en1_ack;
	logic               dramra_rdy;
	logic               dramra_ack;
	dma_pkg::addr_t     dramra;
	logic               dramrd_rdy;
	logic               dramrd_ack;
	dma_pkg::burst_t    dramrd;
	logic               write0_dval;
	logic               write1_dval;
	dma_pkg::hiaddr_t   whiaddr0;
	dma_pkg::hiaddr_t   whiaddr1;
	dma_pkg::vec_t      rmc_wdata;

	int               errors = 0;
	int               n_acc = 0;
	int               n_rp = 0;
	int               n_addr = 0;
	int               n_rd = 0;
	int               n_wr = 0;
	bit               gate_seen [n_chunks];
	dma_pkg::hiaddr_t exp_ptr [2];

	always #10 clk = ~clk;

	dma_pipeline dut0 (
		.i_clk(clk), .i_rst(rst),
		.i_bofs_rdy(bofs_rdy), .o_bofs_ack(bofs_ack),
		.i_which(which), .i_cfg_id(cfg_id), .i_row(row), .i_col(col),
		.i_cfg0_base(cfg0_base), .i_cfg1_base(cfg1_base),
		.i_cfg0_pitch(cfg0_pitch), .i_cfg1_pitch(cfg1_pitch),
		.i_cfg0_xor(cfg0_xor), .i_cfg1_xor(cfg1_xor),
		.i_rp_en0_rdy(rp_en0_rdy), .o_rp_en0_ack(rp_en0_ack),
		.i_rp_en1_rdy(rp_en1_rdy), .o_rp_en1_ack(rp_en1_ack),
		.o_dramra_rdy(dramra_rdy), .i_dramra_ack(dramra_ack), .o_dramra(dramra),
		.i_dramrd_rdy(dramrd_rdy), .o_dramrd_ack(dramrd_ack), .i_dramrd(dramrd),
		.o_rmc_write0_dval(write0_dval), .o_rmc_write1_dval(write1_dval),
		.o_rmc_whiaddr0(whiaddr0), .o_rmc_whiaddr1(whiaddr1),
		.o_rmc_wdata(rmc_wdata)
	);

	dram_responder u_dram (
		.i_clk(clk),
		.i_ra_rdy(dramra_rdy), .i_ra(dramra), .o_ra_ack(dramra_ack),
		.o_rd_rdy(dramrd_rdy), .i_rd_ack(dramrd_ack), .o_rd(dramrd)
	);

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act) else begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// Word k of the response to an address
	function automatic dma_pkg::word_t burst_word(input dma_pkg::addr_t addr, input int k);
		return dma_pkg::word_t'(32'(addr) * 8 + k);
	endfunction

	// Read pipelines ask for data with random gaps
	initial begin
		void'($urandom(32'h8bc0b55b));
		rp_en0_rdy = 1'b0;
		rp_en1_rdy = 1'b0;
		forever begin
			@(negedge clk);
			rp_en0_rdy = ($urandom_range(3, 0) != 0);
			rp_en1_rdy = ($urandom_range(3, 0) != 0);
		end
	end

	//==============================
	// Monitor that samples late in each cycle
	//==============================
	always begin
		int                 k;
		int                 half;
		int                 src;
		logic               side;
		dma_pkg::lane_sel_t mask;
		@(negedge clk);
		#1;
		if (!rst) begin
			if (dramra_rdy && n_addr < n_chunks) begin
				assert (gate_seen[n_addr])
				else report_problem("DRAM address shown before its read pipeline was ready");
			end
			if (dramra_rdy && dramra_ack) begin
				if (n_addr < n_chunks) begin
					check_value("dram_addr", chunks[n_addr].addr, dramra);
				end else begin
					report_problem("more DRAM addresses than chunks");
				end
				n_addr++;
			end
			if (dramrd_rdy && dramrd_ack) begin
				n_rd++;
			end
			// Head holds the newest accepted chunk
			if (n_acc > 0) begin
				if (chunks[n_acc-1].which ? rp_en1_rdy : rp_en0_rdy) begin
					gate_seen[n_acc-1] = 1'b1;
				end
			end
			assert (!(rp_en0_ack && !rp_en0_rdy))
			else report_problem("rp_en0 acknowledged while rp_en0 was not ready");
			assert (!(rp_en1_ack && !rp_en1_rdy))
			else report_problem("rp_en1 acknowledged while rp_en1 was not ready");
			assert (!(rp_en0_ack && rp_en1_ack))
			else report_problem("both rp_en acknowledges in one cycle");
			if (rp_en0_ack || rp_en1_ack) begin
				if (n_rp < n_chunks) begin
					check_value("rp_en_side", chunks[n_rp].which, rp_en1_ack);
				end else begin
					report_problem("more rp_en acknowledges than chunks");
				end
				n_rp++;
			end
			if (bofs_rdy && bofs_ack) begin
				n_acc++;
			end
			if (write0_dval || write1_dval) begin
				assert (!(write0_dval && write1_dval))
				else report_problem("both SRAM write strobes high");
				if (n_wr < 2 * n_chunks) begin
					k    = n_wr / 2;
					half = n_wr % 2;
					side = chunks[k].which;
					mask = side ? cfg1_xor[chunks[k].cfg_id] : cfg0_xor[chunks[k].cfg_id];
					check_value("write_side", side, write1_dval);
					check_value("write_hiaddr", exp_ptr[side], side ? whiaddr1 : whiaddr0);
					for (int lane = 0; lane < `DMA_VSIZE; lane++) begin
						src = lane ^ int'(exp_ptr[side][1:0] & mask);
						check_value("write_data",
							burst_word(chunks[k].addr, half * `DMA_VSIZE + src),
							rmc_wdata[lane]);
					end
					exp_ptr[side] = exp_ptr[side] + 1'b1;
				end else begin
					report_problem("more SRAM writes than expected");
				end
				n_wr++;
			end
		end
	end

	//==============================
	// Stimulus
	//==============================
	initial begin
		int   cycles;
		logic stalled;
		cfg0_base  = '{16'h0100, 16'h0800};
		cfg1_base  = '{16'h2000, 16'h3400};
		cfg0_pitch = '{16'd16, 16'd24};
		cfg1_pitch = '{16'd9, 16'd32};
		cfg0_xor   = '{2'b00, 2'b01};
		cfg1_xor   = '{2'b00, 2'b11};
		exp_ptr    = '{4'd0, 4'd0};
		bofs_rdy   = 1'b0;
		which      = 1'b0;
		cfg_id     = '0;
		row        = '0;
		col        = '0;
		stalled    = 1'b0;
		rst        = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		check_value("reset_outputs", 7'b0, {bofs_ack, rp_en0_ack, rp_en1_ack,
			dramra_rdy, dramrd_ack, write0_dval, write1_dval});

		for (int i = 0; i < n_chunks && !stalled; i++) begin
			@(negedge clk);
			bofs_rdy = 1'b1;
			which    = chunks[i].which;
			cfg_id   = chunks[i].cfg_id;
			row      = chunks[i].row;
			col      = chunks[i].col;
			#1;
			cycles = 0;
			while (!bofs_ack && cycles < 200) begin
				@(negedge clk);
				#1;
				cycles++;
			end
			assert (bofs_ack) else begin
				report_problem("timeout waiting for the chunk request acknowledge");
				stalled = 1'b1;
			end
		end
		@(negedge clk);
		bofs_rdy = 1'b0;

		cycles = 0;
		while (!stalled && n_wr < 2 * n_chunks && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		assert (stalled || n_wr >= 2 * n_chunks)
		else report_problem("timeout waiting for the SRAM writes");

		// Let any stray output show up before counting
		repeat (10) @(negedge clk);
		check_value("addr_count", n_chunks, n_addr);
		check_value("response_count", n_chunks, n_rd);
		check_value("rp_en_count", n_chunks, n_rp);
		check_value("write_count", 2 * n_chunks, n_wr);

		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: bench/dram_responder.sv
`include "dma_settings.svh"

module dram_responder (
	input  logic            i_clk,
	input  logic            i_ra_rdy,
	input  dma_pkg::addr_t  i_ra,
	output logic            o_ra_ack,
	output logic            o_rd_rdy,
	input  logic            i_rd_ack,
	output dma_pkg::burst_t o_rd
);

	dma_pkg::addr_t pending [$];
	dma_pkg::addr_t taken;
	int             delay;
	logic           armed;

	initial begin
		o_ra_ack = 1'b0;
		o_rd_rdy = 1'b0;
		armed    = 1'b0;
		delay    = 0;
		taken    = '0;
		for (int k = 0; k < `DMA_CSIZE; k++) begin
			o_rd[k] = '0;
		end
		forever begin
			@(negedge i_clk);
			// Address was taken at the last rising edge
			if (o_ra_ack) begin
				pending.push_back(taken);
				o_ra_ack = 1'b0;
			end
			// Acknowledge after 0 to 3 cycles
			if (i_ra_rdy) begin
				if (!armed) begin
					delay = $urandom_range(3, 0);
					armed = 1'b1;
				end
				if (delay == 0) begin
					o_ra_ack = 1'b1;
					taken    = i_ra;
					armed    = 1'b0;
				end else begin
					delay--;
				end
			end
			// Oldest address is answered first
			o_rd_rdy = (pending.size() > 0);
			if (o_rd_rdy) begin
				for (int k = 0; k < `DMA_CSIZE; k++) begin
					o_rd[k] = dma_pkg::word_t'(32'(pending[0]) * 8 + k);
				end
			end
			#1;
			if (o_rd_rdy && i_rd_ack) begin
				void'(pending.pop_front());
			end
		end
	end

endmodule

// File: source/dma_pipeline.sv
`include "dma_settings.svh"

module dma_pipeline (
	input  logic               i_clk,
	input  logic               i_rst,
	// Chunk request
	input  logic               i_bofs_rdy,
	output logic               o_bofs_ack,
	input  logic               i_which,
	input  dma_pkg::cfg_id_t   i_cfg_id,
	input  dma_pkg::crd_t      i_row,
	input  dma_pkg::crd_t      i_col,
	// Configuration tables
	input  dma_pkg::addr_t     i_cfg0_base  [`DMA_N_CFG],
	input  dma_pkg::addr_t     i_cfg1_base  [`DMA_N_CFG],
	input  dma_pkg::addr_t     i_cfg0_pitch [`DMA_N_CFG],
	input  dma_pkg::addr_t     i_cfg1_pitch [`DMA_N_CFG],
	input  dma_pkg::lane_sel_t i_cfg0_xor   [`DMA_N_CFG],
	input  dma_pkg::lane_sel_t i_cfg1_xor   [`DMA_N_CFG],
	// Read pipeline requests
	input  logic               i_rp_en0_rdy,
	output logic               o_rp_en0_ack,
	input  logic               i_rp_en1_rdy,
	output logic               o_rp_en1_ack,
	// DRAM
	output logic               o_dramra_rdy,
	input  logic               i_dramra_ack,
	output dma_pkg::addr_t     o_dramra,
	input  logic               i_dramrd_rdy,
	output logic               o_dramrd_ack,
	input  dma_pkg::burst_t    i_dramrd,
	// SRAM writes
	output logic               o_rmc_write0_dval,
	output logic               o_rmc_write1_dval,
	output dma_pkg::hiaddr_t   o_rmc_whiaddr0,
	output dma_pkg::hiaddr_t   o_rmc_whiaddr1,
	output dma_pkg::vec_t      o_rmc_wdata
);

	chunk_if   to_addr();
	chunk_if   to_wr();
	sram_wr_if wr();

	chunk_head u_chunk_head (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_bofs_rdy  (i_bofs_rdy),
		.o_bofs_ack  (o_bofs_ack),
		.i_which     (i_which),
		.i_cfg_id    (i_cfg_id),
		.i_row       (i_row),
		.i_col       (i_col),
		.i_cfg0_pitch(i_cfg0_pitch),
		.i_cfg1_pitch(i_cfg1_pitch),
		.i_rp_en0_rdy(i_rp_en0_rdy),
		.i_rp_en1_rdy(i_rp_en1_rdy),
		.o_rp_en0_ack(o_rp_en0_ack),
		.o_rp_en1_ack(o_rp_en1_ack),
		.to_addr     (to_addr.src),
		.to_wr       (to_wr.src)
	);

	//============================
	// Address branch
	//============================
	dram_addr_issuer u_addr (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.chunk       (to_addr.dst),
		.i_cfg0_base (i_cfg0_base),
		.i_cfg1_base (i_cfg1_base),
		.o_dramra_rdy(o_dramra_rdy),
		.i_dramra_ack(i_dramra_ack),
		.o_dramra    (o_dramra)
	);

	//============================
	// Write branch
	//============================
	sram_write_collector u_swc (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.chunk       (to_wr.dst),
		.i_dramrd_rdy(i_dramrd_rdy),
		.o_dramrd_ack(o_dramrd_ack),
		.i_dramrd    (i_dramrd),
		.wr          (wr.src)
	);

	butterfly_write_if u_wif (
		.wr               (wr.dst),
		.i_cfg0_xor       (i_cfg0_xor),
		.i_cfg1_xor       (i_cfg1_xor),
		.o_rmc_write0_dval(o_rmc_write0_dval),
		.o_rmc_write1_dval(o_rmc_write1_dval),
		.o_rmc_whiaddr0   (o_rmc_whiaddr0),
		.o_rmc_whiaddr1   (o_rmc_whiaddr1),
		.o_rmc_wdata      (o_rmc_wdata)
	);

endmodule

// File: source/butterfly_write_if.sv
`include "dma_settings.svh"

module butterfly_write_if (
	sram_wr_if.dst              wr,
	input  dma_pkg::lane_sel_t  i_cfg0_xor [`DMA_N_CFG],
	input  dma_pkg::lane_sel_t  i_cfg1_xor [`DMA_N_CFG],
	output logic                o_rmc_write0_dval,
	output logic                o_rmc_write1_dval,
	output dma_pkg::hiaddr_t    o_rmc_whiaddr0,
	output dma_pkg::hiaddr_t    o_rmc_whiaddr1,
	output dma_pkg::vec_t       o_rmc_wdata
);

	dma_pkg::lane_sel_t mask;
	dma_pkg::lane_sel_t lane_xor;

	always_comb begin
		if (wr.which) begin
			mask = i_cfg1_xor[wr.cfg_id];
		end else begin
			mask = i_cfg0_xor[wr.cfg_id];
		end
	end

	// Bank rotation follows the low pointer bits
	assign lane_xor = dma_pkg::lane_sel_t'(wr.hiaddr) & mask;

	always_comb begin
		for (int i = 0; i < `DMA_VSIZE; i++) begin
			o_rmc_wdata[i] = wr.data[dma_pkg::lane_sel_t'(i) ^ lane_xor];
		end
	end

	// Only the chunk's side sees the strobe
	assign o_rmc_write0_dval = wr.dval && !wr.which;
	assign o_rmc_write1_dval = wr.dval && wr.which;
	assign o_rmc_whiaddr0    = wr.which ? '0 : wr.hiaddr;
	assign o_rmc_whiaddr1    = wr.which ? wr.hiaddr : '0;

endmodule

// File: source/sram_write_collector.sv
`include "dma_settings.svh"

module sram_write_collector (
	input  logic            i_clk,
	input  logic            i_rst,
	chunk_if.dst            chunk,
	input  logic            i_dramrd_rdy,
	output logic            o_dramrd_ack,
	input  dma_pkg::burst_t i_dramrd,
	sram_wr_if.src          wr
);

	//============================
	// Pending chunk command
	//============================
	dma_pkg::chunk_cmd_t in_cmd;
	dma_pkg::chunk_cmd_t cmd;
	logic                cmd_rdy;
	logic                cmd_ack;

	assign in_cmd.which  = chunk.which;
	assign in_cmd.cfg_id = chunk.cfg_id;
	assign in_cmd.mofs   = chunk.mofs;

	forward_stage #(
		.T(dma_pkg::chunk_cmd_t)
	) u_fwd_cmd (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (chunk.rdy),
		.o_src_ack (chunk.ack),
		.i_src_data(in_cmd),
		.o_dst_rdy (cmd_rdy),
		.i_dst_ack (cmd_ack),
		.o_dst_data(cmd)
	);

	//============================
	// Response capture and write
	//============================
	logic             busy;
	logic             half;
	logic             cur_which;
	dma_pkg::cfg_id_t cur_cfg_id;
	dma_pkg::burst_t  burst;
	dma_pkg::hiaddr_t ptr [2];
	dma_pkg::vec_t    vec;

	// Responses come back in address order, so the oldest command owns it
	assign o_dramrd_ack = cmd_rdy && !busy && i_dramrd_rdy;
	assign cmd_ack      = o_dramrd_ack;

	always_ff @(posedge i_clk) begin
		if (o_dramrd_ack) begin
			burst      <= i_dramrd;
			cur_which  <= cmd.which;
			cur_cfg_id <= cmd.cfg_id;
		end
	end

	// Two back-to-back writes with the low half first
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy   <= 1'b0;
			half   <= 1'b0;
			ptr[0] <= '0;
			ptr[1] <= '0;
		end else begin
			if (o_dramrd_ack) begin
				busy <= 1'b1;
				half <= 1'b0;
			end else if (busy) begin
				half <= !half;
				if (half) begin
					busy <= 1'b0;
				end
			end
			// Per-side pointer wraps on its own
			if (busy) begin
				ptr[cur_which] <= ptr[cur_which] + 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `DMA_VSIZE; i++) begin
			vec[i] = half ? burst[i+`DMA_VSIZE] : burst[i];
		end
	end

	assign wr.dval   = busy;
	assign wr.which  = cur_which;
	assign wr.cfg_id = cur_cfg_id;
	assign wr.hiaddr = ptr[cur_which];
	assign wr.data   = vec;

endmodule

// File: source/dram_addr_issuer.sv
`include "dma_settings.svh"

module dram_addr_issuer (
	input  logic           i_clk,
	input  logic           i_rst,
	chunk_if.dst           chunk,
	input  dma_pkg::addr_t i_cfg0_base [`DMA_N_CFG],
	input  dma_pkg::addr_t i_cfg1_base [`DMA_N_CFG],
	output logic           o_dramra_rdy,
	input  logic           i_dramra_ack,
	output dma_pkg::addr_t o_dramra
);

	dma_pkg::addr_t sel_base;
	dma_pkg::addr_t full_addr;

	// Base of the chunk's own configuration
	always_comb begin
		if (chunk.which) begin
			sel_base = i_cfg1_base[chunk.cfg_id];
		end else begin
			sel_base = i_cfg0_base[chunk.cfg_id];
		end
	end

	assign full_addr = sel_base + chunk.mofs;

	// Registered address stays on the bus until DRAM takes it
	forward_stage #(
		.T(dma_pkg::addr_t)
	) u_fwd_addr (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (chunk.rdy),
		.o_src_ack (chunk.ack),
		.i_src_data(full_addr),
		.o_dst_rdy (o_dramra_rdy),
		.i_dst_ack (i_dramra_ack),
		.o_dst_data(o_dramra)
	);

endmodule

// File: source/chunk_head.sv
`include "dma_settings.svh"

module chunk_head (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_bofs_rdy,
	output logic             o_bofs_ack,
	input  logic             i_which,
	input  dma_pkg::cfg_id_t i_cfg_id,
	input  dma_pkg::crd_t    i_row,
	input  dma_pkg::crd_t    i_col,
	input  dma_pkg::addr_t   i_cfg0_pitch [`DMA_N_CFG],
	input  dma_pkg::addr_t   i_cfg1_pitch [`DMA_N_CFG],
	input  logic             i_rp_en0_rdy,
	input  logic             i_rp_en1_rdy,
	output logic             o_rp_en0_ack,
	output logic             o_rp_en1_ack,
	chunk_if.src             to_addr,
	chunk_if.src             to_wr
);

	//============================
	// Offset of the incoming chunk
	//============================
	dma_pkg::addr_t sel_pitch;
	always_comb begin
		if (i_which) begin
			sel_pitch = i_cfg1_pitch[i_cfg_id];
		end else begin
			sel_pitch = i_cfg0_pitch[i_cfg_id];
		end
	end

	logic             full;
	logic             done_addr;
	logic             done_wr;
	logic             ch_which;
	dma_pkg::cfg_id_t ch_cfg_id;
	dma_pkg::addr_t   ch_mofs;
	logic             rp_rdy;
	logic             go;
	logic             fin;

	// One chunk at a time
	assign o_bofs_ack = i_bofs_rdy && !full;

	always_ff @(posedge i_clk) begin
		if (o_bofs_ack) begin
			ch_which  <= i_which;
			ch_cfg_id <= i_cfg_id;
			ch_mofs   <= dma_pkg::addr_t'(i_row) * sel_pitch + dma_pkg::addr_t'(i_col);
		end
	end

	//============================
	// Broadcast to both branches
	//============================
	// Held until the read pipeline of that side asks for data
	assign rp_rdy = ch_which ? i_rp_en1_rdy : i_rp_en0_rdy;
	assign go     = full && rp_rdy;

	assign to_addr.rdy    = go && !done_addr;
	assign to_addr.which  = ch_which;
	assign to_addr.cfg_id = ch_cfg_id;
	assign to_addr.mofs   = ch_mofs;

	assign to_wr.rdy    = go && !done_wr;
	assign to_wr.which  = ch_which;
	assign to_wr.cfg_id = ch_cfg_id;
	assign to_wr.mofs   = ch_mofs;

	// Last outstanding branch takes the chunk this cycle
	assign fin = full && (done_addr || to_addr.ack) && (done_wr || to_wr.ack);

	assign o_rp_en0_ack = fin && !ch_which;
	assign o_rp_en1_ack = fin && ch_which;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full      <= 1'b0;
			done_addr <= 1'b0;
			done_wr   <= 1'b0;
		end else if (o_bofs_ack) begin
			full      <= 1'b1;
			done_addr <= 1'b0;
			done_wr   <= 1'b0;
		end else if (fin) begin
			full      <= 1'b0;
			done_addr <= 1'b0;
			done_wr   <= 1'b0;
		end else begin
			if (to_addr.ack) begin
				done_addr <= 1'b1;
			end
			if (to_wr.ack) begin
				done_wr <= 1'b1;
			end
		end
	end

endmodule

// File: source/forward_stage.sv
module forward_stage #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_src_rdy,
	output logic o_src_ack,
	input  T     i_src_data,
	output logic o_dst_rdy,
	input  logic i_dst_ack,
	output T     o_dst_data
);

	logic full;

	// Refill in the same cycle the output drains
	assign o_src_ack = i_src_rdy && (!full || i_dst_ack);
	assign o_dst_rdy = full;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full <= 1'b0;
		end else if (o_src_ack) begin
			full <= 1'b1;
		end else if (i_dst_ack) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			o_dst_data <= i_src_data;
		end
	end

endmodule

// File: source/dma_ifs.sv
// Chunk broadcast from the head to one branch
interface chunk_if;
	logic             rdy;
	logic             ack;
	logic             which;
	dma_pkg::cfg_id_t cfg_id;
	dma_pkg::addr_t   mofs;

	modport src(output rdy, input ack, output which, output cfg_id, output mofs);
	modport dst(input rdy, output ack, input which, input cfg_id, input mofs);
endinterface

// SRAM vector write with a valid pulse and no acknowledge
interface sram_wr_if;
	logic             dval;
	logic             which;
	dma_pkg::cfg_id_t cfg_id;
	dma_pkg::hiaddr_t hiaddr;
	dma_pkg::vec_t    data;

	modport src(
		output dval, output which, output cfg_id, output hiaddr, output data
	);
	modport dst(
		input dval, input which, input cfg_id, input hiaddr, input data
	);
endinterface

// File: source/dma_pkg.sv
`include "dma_settings.svh"

package dma_pkg;

	// Scalar types
	typedef logic [`DMA_DBW-1:0] word_t;
	typedef logic [`DMA_GBW-1:0] addr_t;
	typedef logic [$clog2(`DMA_N_CFG)-1:0] cfg_id_t;
	typedef logic [`DMA_CRD_BW-1:0] crd_t;
	typedef logic [`DMA_HBW-1:0] hiaddr_t;
	typedef logic [$clog2(`DMA_VSIZE)-1:0] lane_sel_t;

	// One chunk on its way to a branch
	typedef struct packed {
		logic    which;
		cfg_id_t cfg_id;
		addr_t   mofs;
	} chunk_cmd_t;

	// One DRAM response
	typedef word_t burst_t [`DMA_CSIZE];

	// One SRAM write vector
	typedef word_t vec_t [`DMA_VSIZE];

endpackage

// File: source/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

//============================
// Configuration table
//============================
// Configurations per side
`define DMA_N_CFG 2

//============================
// Data and address widths
//============================
`define DMA_DBW 16
`define DMA_GBW 16
// Words per DRAM response and lanes per SRAM vector
`define DMA_CSIZE 8
`define DMA_VSIZE 4
// SRAM vector pointer for 16 vectors per side
`define DMA_HBW 4
// Chunk row and column coordinates
`define DMA_CRD_BW 4

`endif
